// File: list.f
+incdir+test
verilog/i2c_init_pkg.sv
verilog/init_table_rom.sv
verilog/cmd_channel.sv
verilog/data_channel.sv
verilog/init_sequencer.sv
verilog/i2c_init.sv
test/tb_i2c_init.sv

// File: test/tb_i2c_init_tasks.svh
// i2c init testbench tasks
`ifndef TB_I2C_INIT_TASKS_SVH
`define TB_I2C_INIT_TASKS_SVH

// model address and pending start
dev_addr_t model_addr;
logic      model_pend;

task automatic abort_run(string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "stopped at first error");
endtask

task automatic compare_addr(string name, dev_addr_t got, dev_addr_t exp);
    if (got !== exp) begin
        abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic compare_byte(string name, byte_t got, byte_t exp);
    if (got !== exp) begin
        abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
    end
endtask

function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
endfunction

// bit 8 is data, top bits 01 start a write
function automatic logic is_data(entry_t e);
    return e[8];
endfunction

function automatic logic is_start(entry_t e);
    return e[8:7] == 2'b01;
endfunction

task automatic expect_write(byte_t b);
    exp_cmd.push_back({model_addr, model_pend, 1'b1, 1'b0});
    exp_data.push_back(b);
    model_pend = 1'b0;
endtask

// address stays on the bus with a stop
task automatic expect_stop();
    exp_cmd.push_back({model_addr, 1'b0, 1'b0, 1'b1});
    model_pend = 1'b0;
endtask

// one entry inside a replayed data block
task automatic model_block_entry(entry_t e, dev_addr_t cur);
    if (is_data(e)) begin
        expect_write(e[7:0]);
    end else if (is_start(e)) begin
        model_addr = e[6:0];
        model_pend = 1'b1;
    end else if (e == ENT_WRITE_CUR) begin
        model_addr = cur;
        model_pend = 1'b1;
    end else if (e == ENT_SEND_STOP) begin
        expect_stop();
    end
endtask

// walk the table into expected transfer lists
task automatic build_expected();
    int     p;
    int     q;
    int     r;
    int     blk;
    entry_t e;
    logic   done;
    p          = 0;
    done       = 1'b0;
    model_pend = 1'b0;
    while (!done && p < TABLE_LEN) begin
        e = INIT_TABLE[p];
        if (is_data(e)) begin
            expect_write(e[7:0]);
        end else if (is_start(e)) begin
            model_addr = e[6:0];
            model_pend = 1'b1;
        end else if (e == ENT_SEND_STOP) begin
            expect_stop();
        end else if (e == ENT_STOP) begin
            expect_stop();
            done = 1'b1;
        end else if (e == ENT_DATA_BLOCK) begin
            // block ends at the address list marker
            blk = p + 1;
            q   = blk;
            while (q < TABLE_LEN && INIT_TABLE[q] != ENT_ADDR_BLOCK) begin
                q++;
            end
            // one replay per listed address
            for (q = q + 1; q < TABLE_LEN && is_start(INIT_TABLE[q]); q++) begin
                for (r = blk; r < TABLE_LEN && INIT_TABLE[r] != ENT_ADDR_BLOCK; r++) begin
                    model_block_entry(INIT_TABLE[r], INIT_TABLE[q][6:0]);
                end
            end
            // q sits on the exit entry
            p = q;
        end
        // invalid and exit entries only advance
        p++;
    end
endtask

task automatic set_ready(logic use_random, logic level);
    @(posedge clk);
    random_ready <= use_random;
    ready_level  <= level;
endtask

task automatic clear_collected();
    @(negedge clk);
    got_cmd.delete();
    got_data.delete();
    busy_seen = 1'b0;
endtask

task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
endtask

// last transfer is the final stop
task automatic wait_sequence();
    while (got_cmd.size() < exp_cmd.size()) begin
        @(negedge clk);
    end
    repeat (IDLE_WINDOW) @(negedge clk);
endtask

task automatic check_sequence();
    if (got_cmd.size() != exp_cmd.size()) begin
        abort_run($sformatf("expected %0d command transfers but saw %0d",
                            exp_cmd.size(), got_cmd.size()));
    end
    if (got_data.size() != exp_data.size()) begin
        abort_run($sformatf("expected %0d data transfers but saw %0d",
                            exp_data.size(), got_data.size()));
    end
    foreach (exp_cmd[i]) begin
        compare_addr($sformatf("cmd_address[%0d]", i), got_cmd[i].addr, exp_cmd[i].addr);
        compare_bit($sformatf("cmd_start[%0d]", i), got_cmd[i].start, exp_cmd[i].start);
        compare_bit($sformatf("cmd_write[%0d]", i), got_cmd[i].write, exp_cmd[i].write);
        compare_bit($sformatf("cmd_stop[%0d]", i), got_cmd[i].stop, exp_cmd[i].stop);
    end
    foreach (exp_data[i]) begin
        compare_byte($sformatf("data_out[%0d]", i), got_data[i], exp_data[i]);
    end
    if (!busy_seen) begin
        abort_run("busy never went high during the run");
    end
    compare_bit("busy", busy, 1'b0);
endtask

task automatic test_reset_state();
    repeat (20) begin
        @(negedge clk);
        compare_bit("cmd_valid", cmd_valid, 1'b0);
        compare_bit("data_out_valid", data_out_valid, 1'b0);
        compare_bit("busy", busy, 1'b0);
    end
endtask

task automatic test_full_sequence();
    set_ready(1'b0, 1'b1);
    clear_collected();
    pulse_start();
    wait_sequence();
    check_sequence();
endtask

task automatic test_random_backpressure();
    set_ready(1'b1, 1'b0);
    clear_collected();
    pulse_start();
    wait_sequence();
    check_sequence();
    set_ready(1'b0, 1'b1);
endtask

// start stays high long after the run ends
task automatic test_start_held();
    clear_collected();
    @(posedge clk);
    start <= 1'b1;
    wait_sequence();
    repeat (2 * IDLE_WINDOW) @(negedge clk);
    check_sequence();
endtask

task automatic test_rerun();
    @(posedge clk);
    start <= 1'b0;
    repeat (2) @(posedge clk);
    clear_collected();
    pulse_start();
    wait_sequence();
    check_sequence();
endtask

`endif

// File: test/tb_i2c_init.sv
// i2c init testbench
module tb_i2c_init
    import i2c_init_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // about four full runs under heavy back-pressure
    localparam int TIMEOUT_CYCLES = 4000;
    // quiet cycles after a run to catch extra transfers
    localparam int IDLE_WINDOW    = 20;

    // one accepted command transfer
    typedef struct packed {
        dev_addr_t addr;
        logic      start;
        logic      write;
        logic      stop;
    } cmd_txn_t;

    logic      clk;
    logic      rst;
    logic      start;
    logic      cmd_ready;
    logic      data_out_ready;
    dev_addr_t cmd_address;
    logic      cmd_start;
    logic      cmd_write;
    logic      cmd_stop;
    logic      cmd_valid;
    byte_t     data_out;
    logic      data_out_valid;
    logic      busy;

    // ready drive control
    logic   random_ready = 1'b0;
    logic   ready_level  = 1'b0;
    integer seed         = 32'h824f4cda;
    int     cycle_count  = 0;
    logic   busy_seen    = 1'b0;

    // model output and monitor capture
    cmd_txn_t exp_cmd[$];
    cmd_txn_t got_cmd[$];
    byte_t    exp_data[$];
    byte_t    got_data[$];

    // stalled payload from the previous edge
    cmd_txn_t cur_cmd;
    cmd_txn_t hold_cmd;
    logic     cmd_hold  = 1'b0;
    byte_t    hold_data;
    logic     data_hold = 1'b0;

    assign cur_cmd = {cmd_address, cmd_start, cmd_write, cmd_stop};

    `include "tb_i2c_init_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    i2c_init dut (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .busy           (busy)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("run did not finish within the cycle limit");
        end
    end

    // both readies random or both at a fixed level
    always @(posedge clk) begin
        if (random_ready) begin
            cmd_ready      <= rand_bit();
            data_out_ready <= rand_bit();
        end else begin
            cmd_ready      <= ready_level;
            data_out_ready <= ready_level;
        end
    end

    // command monitor, stalled payload must not move
    always @(posedge clk) begin
        if (cmd_hold) begin
            compare_bit("cmd_valid held", cmd_valid, 1'b1);
            compare_addr("cmd_address held", cmd_address, hold_cmd.addr);
            compare_bit("cmd_start held", cmd_start, hold_cmd.start);
            compare_bit("cmd_write held", cmd_write, hold_cmd.write);
            compare_bit("cmd_stop held", cmd_stop, hold_cmd.stop);
        end
        if (cmd_valid && cmd_ready) begin
            got_cmd.push_back(cur_cmd);
        end
        if (busy) begin
            busy_seen = 1'b1;
        end
        cmd_hold = !rst && cmd_valid && !cmd_ready;
        hold_cmd = cur_cmd;
    end

    // data monitor
    always @(posedge clk) begin
        if (data_hold) begin
            compare_bit("data_out_valid held", data_out_valid, 1'b1);
            compare_byte("data_out held", data_out, hold_data);
        end
        if (data_out_valid && data_out_ready) begin
            got_data.push_back(data_out);
        end
        data_hold = !rst && data_out_valid && !data_out_ready;
        hold_data = data_out;
    end

    initial begin
        rst            = 1'b1;
        start          = 1'b0;
        cmd_ready      = 1'b0;
        data_out_ready = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        build_expected();
        test_reset_state();
        test_full_sequence();
        test_random_backpressure();
        test_start_held();
        test_rerun();
        $display("test passed");
        $finish;
    end

endmodule

// File: verilog/cmd_channel.sv
// i2c command output register
module cmd_channel
    import i2c_init_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_load_addr,
    input  dev_addr_t addr,
    input  logic      cmd_load_write,
    input  logic      cmd_load_stop,
    output dev_addr_t cmd_address,
    output logic      cmd_start,
    output logic      cmd_write,
    output logic      cmd_stop,
    output logic      cmd_valid,
    input  logic      cmd_ready,
    output logic      cmd_empty
);

    logic xfer;

    assign xfer      = cmd_valid & cmd_ready;
    assign cmd_empty = ~cmd_valid;

    // address held across commands until the next start entry
    always_ff @(posedge clk) begin
        if (cmd_load_addr) begin
            cmd_address <= addr;
        end
    end

    // start doubles as the pending start flag
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_start <= 1'b0;
            cmd_write <= 1'b0;
            cmd_stop  <= 1'b0;
            cmd_valid <= 1'b0;
        end else begin
            // accepted, drop the flags
            if (xfer) begin
                cmd_start <= 1'b0;
                cmd_write <= 1'b0;
                cmd_stop  <= 1'b0;
                cmd_valid <= 1'b0;
            end
            if (cmd_load_addr) begin
                cmd_start <= 1'b1;
            end
            // write keeps pending start
            if (cmd_load_write) begin
                cmd_write <= 1'b1;
                cmd_stop  <= 1'b0;
                cmd_valid <= 1'b1;
            end
            if (cmd_load_stop) begin
                cmd_start <= 1'b0;
                cmd_write <= 1'b0;
                cmd_stop  <= 1'b1;
                cmd_valid <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/data_channel.sv
// i2c data byte output register
module data_channel
    import i2c_init_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  data_load,
    input  byte_t data_byte,
    output byte_t data_out,
    output logic  data_out_valid,
    input  logic  data_out_ready,
    output logic  data_empty
);

    assign data_empty = ~data_out_valid;

    // payload, only written on load
    always_ff @(posedge clk) begin
        if (data_load) begin
            data_out <= data_byte;
        end
    end

    // valid holds until accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out_valid <= 1'b0;
        end else if (data_load) begin
            data_out_valid <= 1'b1;
        end else if (data_out_ready) begin
            data_out_valid <= 1'b0;
        end
    end

endmodule

// File: verilog/i2c_init.sv
// i2c bus init top level
module i2c_init
    import i2c_init_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    // command channel to i2c master
    output dev_addr_t cmd_address,
    output logic      cmd_start,
    output logic      cmd_write,
    output logic      cmd_stop,
    output logic      cmd_valid,
    input  logic      cmd_ready,
    // data channel to i2c master
    output byte_t     data_out,
    output logic      data_out_valid,
    input  logic      data_out_ready,
    output logic      busy
);

    table_ptr_t rd_ptr;
    entry_t     entry;
    logic       cmd_empty;
    logic       data_empty;
    logic       cmd_load_addr;
    logic       cmd_load_write;
    logic       cmd_load_stop;
    logic       data_load;
    dev_addr_t  addr;
    byte_t      data_byte;

    init_table_rom u_rom (
        .clk    (clk),
        .rst    (rst),
        .rd_ptr (rd_ptr),
        .entry  (entry)
    );

    init_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .entry          (entry),
        .rd_ptr         (rd_ptr),
        .cmd_empty      (cmd_empty),
        .data_empty     (data_empty),
        .cmd_load_addr  (cmd_load_addr),
        .addr           (addr),
        .cmd_load_write (cmd_load_write),
        .cmd_load_stop  (cmd_load_stop),
        .data_load      (data_load),
        .data_byte      (data_byte),
        .busy           (busy)
    );

    cmd_channel u_cmd (
        .clk            (clk),
        .rst            (rst),
        .cmd_load_addr  (cmd_load_addr),
        .addr           (addr),
        .cmd_load_write (cmd_load_write),
        .cmd_load_stop  (cmd_load_stop),
        .cmd_address    (cmd_address),
        .cmd_start      (cmd_start),
        .cmd_write      (cmd_write),
        .cmd_stop       (cmd_stop),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd_empty      (cmd_empty)
    );

    data_channel u_data (
        .clk            (clk),
        .rst            (rst),
        .data_load      (data_load),
        .data_byte      (data_byte),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .data_empty     (data_empty)
    );

endmodule

// File: verilog/i2c_init_pkg.sv
// i2c init shared definitions
package i2c_init_pkg;

    // entry and field widths
    localparam int ENTRY_W    = 9;
    localparam int DEV_ADDR_W = 7;
    localparam int TABLE_LEN  = 24;
    localparam int PTR_W      = $clog2(TABLE_LEN);

    typedef logic [ENTRY_W-1:0]    entry_t;
    typedef logic [DEV_ADDR_W-1:0] dev_addr_t;
    typedef logic [PTR_W-1:0]      table_ptr_t;
    typedef logic [7:0]            byte_t;

    // fixed command codes, top bits 00
    localparam entry_t ENT_STOP       = 9'h000;
    localparam entry_t ENT_EXIT       = 9'h001;
    localparam entry_t ENT_WRITE_CUR  = 9'h003;
    localparam entry_t ENT_ADDR_BLOCK = 9'h008;
    localparam entry_t ENT_DATA_BLOCK = 9'h009;
    localparam entry_t ENT_SEND_STOP  = 9'h041;

    typedef enum logic [3:0] {
        op_stop,
        op_exit_block,
        op_write_cur,
        op_addr_block,
        op_data_block,
        op_send_stop,
        op_start_addr,
        op_write_data,
        op_invalid
    } entry_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_run,
        st_seek_addr_block,
        st_fetch_addr,
        st_run_block
    } seq_state_t;

    // init sequence
    // 01 aaaaaaa start write to address, 1 dddddddd write data
    localparam entry_t INIT_TABLE [TABLE_LEN] = '{
        {2'b01, 7'h50},
        {1'b1, 8'h00},
        {1'b1, 8'h04},
        {1'b1, 8'h11},
        ENT_SEND_STOP,
        {2'b00, 7'h02},
        ENT_DATA_BLOCK,
        ENT_WRITE_CUR,
        {1'b1, 8'hA5},
        {1'b1, 8'h3C},
        ENT_ADDR_BLOCK,
        {2'b01, 7'h20},
        {2'b01, 7'h21},
        {2'b01, 7'h22},
        ENT_EXIT,
        {2'b01, 7'h60},
        {1'b1, 8'h7E},
        ENT_STOP,
        ENT_STOP,
        ENT_STOP,
        ENT_STOP,
        ENT_STOP,
        ENT_STOP,
        ENT_STOP
    };

    // map raw entry to opcode
    function automatic entry_op_t decode_entry(entry_t e);
        entry_op_t op;
        if (e[8]) begin
            op = op_write_data;
        end else if (e[8:7] == 2'b01) begin
            op = op_start_addr;
        end else begin
            case (e)
                ENT_STOP:       op = op_stop;
                ENT_EXIT:       op = op_exit_block;
                ENT_WRITE_CUR:  op = op_write_cur;
                ENT_ADDR_BLOCK: op = op_addr_block;
                ENT_DATA_BLOCK: op = op_data_block;
                ENT_SEND_STOP:  op = op_send_stop;
                default:        op = op_invalid;
            endcase
        end
        return op;
    endfunction

endpackage

// File: verilog/init_sequencer.sv
// init table sequencer
module init_sequencer
    import i2c_init_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  entry_t     entry,
    output table_ptr_t rd_ptr,
    input  logic       cmd_empty,
    input  logic       data_empty,
    output logic       cmd_load_addr,
    output dev_addr_t  addr,
    output logic       cmd_load_write,
    output logic       cmd_load_stop,
    output logic       data_load,
    output byte_t      data_byte,
    output logic       busy
);

    seq_state_t state_reg;
    seq_state_t state_next;

    // table walk pointer and the two block pointers
    table_ptr_t ptr_reg;
    table_ptr_t ptr_next;
    table_ptr_t ptr_inc;
    table_ptr_t data_ptr_reg;
    table_ptr_t data_ptr_next;
    table_ptr_t addr_ptr_reg;
    table_ptr_t addr_ptr_next;

    // device address for write-current entries
    dev_addr_t cur_addr_reg;
    dev_addr_t cur_addr_next;

    logic      start_flag_reg;
    logic      start_flag_next;
    logic      step;
    entry_op_t op;

    assign op      = decode_entry(entry);
    assign step    = cmd_empty & data_empty;
    assign ptr_inc = ptr_reg + PTR_W'(1);

    // rom is addressed with the next pointer
    // so entry matches ptr_reg one cycle later
    assign rd_ptr = ptr_next;

    assign data_byte = entry[7:0];
    assign addr      = (op == op_write_cur) ? cur_addr_reg : entry[DEV_ADDR_W-1:0];

    always_comb begin
        state_next      = state_reg;
        ptr_next        = ptr_reg;
        data_ptr_next   = data_ptr_reg;
        addr_ptr_next   = addr_ptr_reg;
        cur_addr_next   = cur_addr_reg;
        start_flag_next = start_flag_reg;
        cmd_load_addr   = 1'b0;
        cmd_load_write  = 1'b0;
        cmd_load_stop   = 1'b0;
        data_load       = 1'b0;

        // hold everything while either channel is still busy
        if (step) begin
            if (state_reg == st_idle) begin
                // rising start only
                if (start && !start_flag_reg) begin
                    ptr_next        = '0;
                    start_flag_next = 1'b1;
                    state_next      = st_run;
                end
            end else if (op == op_stop) begin
                // end of table in any mode
                cmd_load_stop = 1'b1;
                state_next    = st_idle;
            end else begin
                case (state_reg)
                    st_run: begin
                        ptr_next = ptr_inc;
                        case (op)
                            op_write_data: begin
                                cmd_load_write = 1'b1;
                                data_load      = 1'b1;
                            end
                            op_start_addr: cmd_load_addr = 1'b1;
                            op_send_stop:  cmd_load_stop = 1'b1;
                            op_data_block: begin
                                data_ptr_next = ptr_inc;
                                state_next    = st_seek_addr_block;
                            end
                            // anything else skipped
                            default: ;
                        endcase
                    end
                    st_seek_addr_block: begin
                        ptr_next = ptr_inc;
                        case (op)
                            op_addr_block: begin
                                addr_ptr_next = ptr_inc;
                                state_next    = st_fetch_addr;
                            end
                            // a later data block replaces the first
                            op_data_block: data_ptr_next = ptr_inc;
                            op_exit_block: state_next = st_run;
                            default: ;
                        endcase
                    end
                    st_fetch_addr: begin
                        ptr_next = ptr_inc;
                        case (op)
                            op_start_addr: begin
                                // latch address, replay data block
                                cur_addr_next = entry[DEV_ADDR_W-1:0];
                                addr_ptr_next = ptr_inc;
                                ptr_next      = data_ptr_reg;
                                state_next    = st_run_block;
                            end
                            op_data_block: begin
                                data_ptr_next = ptr_inc;
                                state_next    = st_seek_addr_block;
                            end
                            op_exit_block: state_next = st_run;
                            default: ;
                        endcase
                    end
                    st_run_block: begin
                        ptr_next = ptr_inc;
                        case (op)
                            op_write_data: begin
                                cmd_load_write = 1'b1;
                                data_load      = 1'b1;
                            end
                            op_start_addr: cmd_load_addr = 1'b1;
                            // addr mux picks cur_addr_reg
                            op_write_cur:  cmd_load_addr = 1'b1;
                            op_send_stop:  cmd_load_stop = 1'b1;
                            op_data_block: begin
                                data_ptr_next = ptr_inc;
                                state_next    = st_seek_addr_block;
                            end
                            op_addr_block: begin
                                // back into the address list
                                ptr_next   = addr_ptr_reg;
                                state_next = st_fetch_addr;
                            end
                            op_exit_block: state_next = st_run;
                            default: ;
                        endcase
                    end
                    default: state_next = st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg      <= st_idle;
            ptr_reg        <= '0;
            data_ptr_reg   <= '0;
            addr_ptr_reg   <= '0;
            start_flag_reg <= 1'b0;
            busy           <= 1'b0;
        end else begin
            state_reg      <= state_next;
            ptr_reg        <= ptr_next;
            data_ptr_reg   <= data_ptr_next;
            addr_ptr_reg   <= addr_ptr_next;
            // clears once start goes low
            start_flag_reg <= start & start_flag_next;
            // lags state by one cycle
            busy           <= (state_reg != st_idle);
        end
    end

    always_ff @(posedge clk) begin
        cur_addr_reg <= cur_addr_next;
    end

endmodule

// File: verilog/init_table_rom.sv
// init table read port
module init_table_rom
    import i2c_init_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  table_ptr_t rd_ptr,
    output entry_t     entry
);

    // pointer range covers more than the table
    logic   in_range;
    entry_t rom_word;

    assign in_range = (rd_ptr < TABLE_LEN);

    // out of range reads as stop
    always_comb begin
        if (in_range) begin
            rom_word = INIT_TABLE[rd_ptr];
        end else begin
            rom_word = ENT_STOP;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            entry <= '0;
        end else begin
            entry <= rom_word;
        end
    end

endmodule
